/* build.f */
rtl/decode_pkg.sv
rtl/alu_ctrl_decode.sv
rtl/regfile_mem_decode.sv
rtl/pc_ctrl_decode.sv
rtl/decode_stage.sv
sim/decode_stage_chk.sv
sim/tb_decode_stage.sv

/* rtl/alu_ctrl_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_ctrl_decode (
	input  wire [decode_pkg::instr_w-1:0] instr,
	output decode_pkg::alu_ctrl_t         alu
);

	decode_pkg::opcode_e            opcode;
	logic [decode_pkg::funct_w-1:0] funct;

	assign opcode = decode_pkg::opcode_e'(instr[decode_pkg::instr_w-1 -: decode_pkg::opcode_w]);
	assign funct  = instr[decode_pkg::funct_w-1:0];

	// ALU function and operand modifiers
	always_comb begin
		alu.alu_op = decode_pkg::alu_add;
		alu.inv_a  = 1'b0;
		alu.inv_b  = 1'b0;
		alu.cin    = 1'b0;
		alu.sign   = 1'b0;

		case (opcode)
			decode_pkg::op_subi: begin
				alu.inv_a = 1'b1;
				alu.cin   = 1'b1;
				alu.sign  = 1'b1;
			end
			decode_pkg::op_xori:  alu.alu_op = decode_pkg::alu_xor;
			decode_pkg::op_andni: begin
				alu.alu_op = decode_pkg::alu_and;
				alu.inv_b  = 1'b1;
			end
			decode_pkg::op_roli:  alu.alu_op = decode_pkg::alu_rol;
			decode_pkg::op_slli:  alu.alu_op = decode_pkg::alu_sll;
			decode_pkg::op_rori:  alu.alu_op = decode_pkg::alu_ror;
			decode_pkg::op_srli:  alu.alu_op = decode_pkg::alu_srl;
			decode_pkg::op_btr:   alu.alu_op = decode_pkg::alu_btr;
			decode_pkg::op_alu_arith: begin
				case (funct)
					2'b01: begin
						alu.inv_a = 1'b1;
						alu.cin   = 1'b1;
						alu.sign  = 1'b1;
					end
					2'b10: alu.alu_op = decode_pkg::alu_xor;
					2'b11: begin
						alu.alu_op = decode_pkg::alu_and;
						alu.inv_b  = 1'b1;
					end
					default: alu.alu_op = decode_pkg::alu_add;
				endcase
			end
			// rol, sll, ror, srl in funct order
			decode_pkg::op_alu_shift: alu.alu_op = decode_pkg::alu_op_e'({3'b000, funct});
			decode_pkg::op_seq:   alu.alu_op = decode_pkg::alu_seq;
			decode_pkg::op_slt: begin
				alu.alu_op = decode_pkg::alu_slt;
				alu.sign   = 1'b1;
			end
			decode_pkg::op_sle: begin
				alu.alu_op = decode_pkg::alu_sle;
				alu.sign   = 1'b1;
			end
			decode_pkg::op_sco:   alu.alu_op = decode_pkg::alu_sco;
			decode_pkg::op_beqz:  alu.alu_op = decode_pkg::alu_beqz;
			decode_pkg::op_bnez:  alu.alu_op = decode_pkg::alu_bnez;
			decode_pkg::op_bltz: begin
				alu.alu_op = decode_pkg::alu_bltz;
				alu.sign   = 1'b1;
			end
			decode_pkg::op_bgez: begin
				alu.alu_op = decode_pkg::alu_bgez;
				alu.sign   = 1'b1;
			end
			default: alu.alu_op = decode_pkg::alu_add;
		endcase
	end

	// Operand B source and immediate form
	always_comb begin
		alu.operand_b = decode_pkg::opb_imm;
		alu.imm_sel   = decode_pkg::imm5;
		alu.sign_ext  = 1'b0;

		case (opcode)
			decode_pkg::op_btr, decode_pkg::op_alu_shift, decode_pkg::op_alu_arith,
			decode_pkg::op_seq, decode_pkg::op_slt, decode_pkg::op_sle, decode_pkg::op_sco:
				alu.operand_b = decode_pkg::opb_reg;
			// Arithmetic and address offsets
			decode_pkg::op_addi, decode_pkg::op_subi, decode_pkg::op_st,
			decode_pkg::op_ld, decode_pkg::op_stu:
				alu.sign_ext = 1'b1;
			decode_pkg::op_beqz, decode_pkg::op_bnez, decode_pkg::op_bltz, decode_pkg::op_bgez,
			decode_pkg::op_lbi, decode_pkg::op_jr, decode_pkg::op_jalr: begin
				alu.imm_sel  = decode_pkg::imm8;
				alu.sign_ext = 1'b1;
			end
			// Low byte shifted in as is
			decode_pkg::op_slbi:  alu.imm_sel = decode_pkg::imm8;
			decode_pkg::op_j, decode_pkg::op_jal: begin
				alu.imm_sel  = decode_pkg::imm11;
				alu.sign_ext = 1'b1;
			end
			default: alu.sign_ext = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/decode_pkg.sv */
`default_nettype none

package decode_pkg;

	localparam int instr_w  = 16;
	localparam int opcode_w = 5;
	localparam int funct_w  = 2;

	// Major opcodes in instr[15:11]
	typedef enum logic [opcode_w-1:0] {
		op_halt   = 5'b00000, op_nop    = 5'b00001,
		// J-format and register jumps
		op_j      = 5'b00100, op_jr     = 5'b00101, op_jal    = 5'b00110, op_jalr   = 5'b00111,
		// I1-format
		op_addi   = 5'b01000, op_subi   = 5'b01001, op_xori   = 5'b01010, op_andni  = 5'b01011,
		op_roli   = 5'b10100, op_slli   = 5'b10101, op_rori   = 5'b10110, op_srli   = 5'b10111,
		op_st     = 5'b10000, op_ld     = 5'b10001, op_stu    = 5'b10011,
		// I2-format
		op_beqz   = 5'b01100, op_bnez   = 5'b01101, op_bltz   = 5'b01110, op_bgez   = 5'b01111,
		op_lbi    = 5'b11000, op_slbi   = 5'b10010,
		// R-format, funct picks the operation for the two grouped opcodes
		op_btr    = 5'b11001, op_alu_shift = 5'b11010, op_alu_arith = 5'b11011,
		op_seq    = 5'b11100, op_slt    = 5'b11101, op_sle    = 5'b11110, op_sco    = 5'b11111
	} opcode_e;

	// ALU function codes, rotate and shift codes equal their funct value
	typedef enum logic [4:0] {
		alu_rol  = 5'd0,  alu_sll  = 5'd1,  alu_ror  = 5'd2,  alu_srl  = 5'd3,
		alu_add  = 5'd4,  alu_and  = 5'd5,  alu_or   = 5'd6,  alu_xor  = 5'd7,
		alu_btr  = 5'd8,  alu_seq  = 5'd9,  alu_slt  = 5'd10, alu_sle  = 5'd11,
		alu_sco  = 5'd12, alu_beqz = 5'd13, alu_bnez = 5'd14, alu_bltz = 5'd15,
		alu_bgez = 5'd16
	} alu_op_e;

	typedef enum logic {
		opb_imm = 1'b0,
		opb_reg = 1'b1
	} operand_b_e;

	typedef enum logic [1:0] {
		imm5  = 2'd0,
		imm8  = 2'd1,
		imm11 = 2'd2
	} imm_sel_e;

	// Destination register field
	typedef enum logic [1:0] {
		dst_rd_r = 2'b00,
		dst_rd_i = 2'b01,
		dst_rs   = 2'b10,
		dst_r7   = 2'b11
	} reg_dst_e;

	typedef enum logic [2:0] {
		wb_alu  = 3'd0,
		wb_mem  = 3'd1,
		wb_lbi  = 3'd2,
		wb_slbi = 3'd3,
		wb_link = 3'd4
	} wb_src_e;

	typedef enum logic [1:0] {
		pc_seq    = 2'b00,
		pc_reg    = 2'b01,
		pc_disp   = 2'b10,
		pc_branch = 2'b11
	} pc_src_e;

	typedef struct packed {
		alu_op_e    alu_op;
		logic       inv_a;
		logic       inv_b;
		logic       cin;
		logic       sign;
		operand_b_e operand_b;
		imm_sel_e   imm_sel;
		logic       sign_ext;
	} alu_ctrl_t;

	typedef struct packed {
		logic     reg_write;
		reg_dst_e reg_dst;
		wb_src_e  wb_src;
		logic     mem_read;
		logic     mem_write;
	} regfile_mem_ctrl_t;

	typedef struct packed {
		pc_src_e pc_src;
		logic    halt;
	} pc_ctrl_t;

	typedef struct packed {
		alu_ctrl_t         alu;
		regfile_mem_ctrl_t rf_mem;
		pc_ctrl_t          pc;
	} ctrl_word_t;

endpackage

`default_nettype wire

/* rtl/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire [decode_pkg::instr_w-1:0] instr,
	input  wire                           instr_valid,
	output decode_pkg::ctrl_word_t        ctrl,
	output logic                          ctrl_valid
);

	decode_pkg::alu_ctrl_t         alu_next;
	decode_pkg::regfile_mem_ctrl_t rf_mem_next;
	decode_pkg::pc_ctrl_t          pc_next;
	decode_pkg::ctrl_word_t        ctrl_next;

	alu_ctrl_decode u_alu (
		.instr (instr),
		.alu   (alu_next)
	);

	regfile_mem_decode u_rf_mem (
		.instr  (instr),
		.rf_mem (rf_mem_next)
	);

	pc_ctrl_decode u_pc (
		.instr (instr),
		.pc    (pc_next)
	);

	assign ctrl_next = '{alu: alu_next, rf_mem: rf_mem_next, pc: pc_next};

	// Decode/execute pipeline register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl       <= '0;
			ctrl_valid <= 1'b0;
		end else begin
			ctrl_valid <= instr_valid;
			// Word holds through bubbles
			if (instr_valid) begin
				ctrl <= ctrl_next;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/pc_ctrl_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_ctrl_decode (
	input  wire [decode_pkg::instr_w-1:0] instr,
	output decode_pkg::pc_ctrl_t          pc
);

	decode_pkg::opcode_e opcode;

	// Next PC depends on the opcode alone
	assign opcode = decode_pkg::opcode_e'(instr[decode_pkg::instr_w-1 -: decode_pkg::opcode_w]);

	always_comb begin
		pc.pc_src = decode_pkg::pc_seq;
		pc.halt   = 1'b0;

		case (opcode)
			// Taken or not is resolved by the ALU later
			decode_pkg::op_beqz, decode_pkg::op_bnez,
			decode_pkg::op_bltz, decode_pkg::op_bgez:
				pc.pc_src = decode_pkg::pc_branch;
			// PC relative displacement
			decode_pkg::op_j, decode_pkg::op_jal:
				pc.pc_src = decode_pkg::pc_disp;
			// Register plus imm8
			decode_pkg::op_jr, decode_pkg::op_jalr:
				pc.pc_src = decode_pkg::pc_reg;
			decode_pkg::op_halt:
				pc.halt = 1'b1;
			default:
				pc.pc_src = decode_pkg::pc_seq;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/regfile_mem_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile_mem_decode (
	input  wire [decode_pkg::instr_w-1:0] instr,
	output decode_pkg::regfile_mem_ctrl_t rf_mem
);

	decode_pkg::opcode_e opcode;

	assign opcode = decode_pkg::opcode_e'(instr[decode_pkg::instr_w-1 -: decode_pkg::opcode_w]);

	always_comb begin
		// No write unless the opcode says so
		rf_mem.reg_write = 1'b0;
		rf_mem.reg_dst   = decode_pkg::dst_rd_i;
		rf_mem.wb_src    = decode_pkg::wb_alu;
		rf_mem.mem_read  = 1'b0;
		rf_mem.mem_write = 1'b0;

		case (opcode)
			decode_pkg::op_btr, decode_pkg::op_alu_shift, decode_pkg::op_alu_arith,
			decode_pkg::op_seq, decode_pkg::op_slt, decode_pkg::op_sle, decode_pkg::op_sco: begin
				rf_mem.reg_write = 1'b1;
				rf_mem.reg_dst   = decode_pkg::dst_rd_r;
			end
			decode_pkg::op_addi, decode_pkg::op_subi, decode_pkg::op_xori, decode_pkg::op_andni,
			decode_pkg::op_roli, decode_pkg::op_slli, decode_pkg::op_rori, decode_pkg::op_srli:
				rf_mem.reg_write = 1'b1;
			decode_pkg::op_ld: begin
				rf_mem.reg_write = 1'b1;
				rf_mem.wb_src    = decode_pkg::wb_mem;
				rf_mem.mem_read  = 1'b1;
			end
			decode_pkg::op_st:  rf_mem.mem_write = 1'b1;
			// Store with base update, the address goes back to rs
			decode_pkg::op_stu: begin
				rf_mem.reg_write = 1'b1;
				rf_mem.reg_dst   = decode_pkg::dst_rs;
				rf_mem.mem_write = 1'b1;
			end
			decode_pkg::op_lbi: begin
				rf_mem.reg_write = 1'b1;
				rf_mem.reg_dst   = decode_pkg::dst_rs;
				rf_mem.wb_src    = decode_pkg::wb_lbi;
			end
			decode_pkg::op_slbi: begin
				rf_mem.reg_write = 1'b1;
				rf_mem.reg_dst   = decode_pkg::dst_rs;
				rf_mem.wb_src    = decode_pkg::wb_slbi;
			end
			// Return address into r7
			decode_pkg::op_jal, decode_pkg::op_jalr: begin
				rf_mem.reg_write = 1'b1;
				rf_mem.reg_dst   = decode_pkg::dst_r7;
				rf_mem.wb_src    = decode_pkg::wb_link;
			end
			default: rf_mem.reg_write = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f build.f --top-module tb_decode_stage -o sim_decode_stage
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_decode_stage 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1

/* sim/decode_stage_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage_chk (
	input wire                         clk,
	input wire                         rst_n,
	input wire                         instr_valid,
	input wire decode_pkg::ctrl_word_t ctrl,
	input wire                         ctrl_valid
);

	// A load and a store never share one word
	mem_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(ctrl.rf_mem.mem_read && ctrl.rf_mem.mem_write))
		else $error("mem_read and mem_write set together");

	halt_no_write: assert property (@(posedge clk) disable iff (!rst_n)
		ctrl.pc.halt |-> !ctrl.rf_mem.reg_write)
		else $error("halt decoded with reg_write set");

	branch_no_write: assert property (@(posedge clk) disable iff (!rst_n)
		(ctrl.pc.pc_src == decode_pkg::pc_branch) |-> !ctrl.rf_mem.reg_write)
		else $error("branch decoded with reg_write set");

	// One cycle of latency on the strobe
	valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
		ctrl_valid == $past(instr_valid))
		else $error("ctrl_valid does not follow instr_valid");

endmodule

`default_nettype wire

/* sim/tb_decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;

	localparam int clk_period = 100;
	localparam int random_items = 600;
	localparam int run_cycles = 4 + 128 + random_items + 20;

	logic                   clk;
	logic                   rst_n;
	logic [15:0]            instr;
	logic                   instr_valid;
	decode_pkg::ctrl_word_t ctrl;
	logic                   ctrl_valid;

	// One-entry model of the pipeline register
	logic                   exp_valid;
	decode_pkg::ctrl_word_t exp_ctrl;
	logic                   capturing;
	decode_pkg::ctrl_word_t seen_words[$];
	logic [31:0]            lfsr_state;

	decode_stage dut0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr       (instr),
		.instr_valid (instr_valid),
		.ctrl        (ctrl),
		.ctrl_valid  (ctrl_valid)
	);

	bind decode_stage decode_stage_chk u_chk (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.ctrl        (ctrl),
		.ctrl_valid  (ctrl_valid)
	);

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			stop_with_failure("Value mismatch, run stopped");
		end
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
	endtask

	function automatic decode_pkg::ctrl_word_t expected_ctrl(input logic [15:0] ins);
		decode_pkg::opcode_e    op;
		logic [1:0]             fn;
		decode_pkg::ctrl_word_t w;
		logic r_fmt, is_sub, is_andn, i1_sext, i1_zext, branch, imm8s, long_jump, link;
		op = decode_pkg::opcode_e'(ins[15:11]);
		fn = ins[1:0];
		r_fmt = op inside {decode_pkg::op_btr, decode_pkg::op_alu_shift, decode_pkg::op_alu_arith,
			decode_pkg::op_seq, decode_pkg::op_slt, decode_pkg::op_sle, decode_pkg::op_sco};
		is_sub = op == decode_pkg::op_subi || (op == decode_pkg::op_alu_arith && fn == 2'd1);
		is_andn = op == decode_pkg::op_andni || (op == decode_pkg::op_alu_arith && fn == 2'd3);
		i1_sext = op inside {decode_pkg::op_addi, decode_pkg::op_subi, decode_pkg::op_st,
			decode_pkg::op_ld, decode_pkg::op_stu};
		i1_zext = op inside {decode_pkg::op_xori, decode_pkg::op_andni, decode_pkg::op_roli,
			decode_pkg::op_slli, decode_pkg::op_rori, decode_pkg::op_srli};
		branch = op inside {decode_pkg::op_beqz, decode_pkg::op_bnez,
			decode_pkg::op_bltz, decode_pkg::op_bgez};
		imm8s = branch || op inside {decode_pkg::op_lbi, decode_pkg::op_jr, decode_pkg::op_jalr};
		long_jump = op inside {decode_pkg::op_j, decode_pkg::op_jal};
		link = op inside {decode_pkg::op_jal, decode_pkg::op_jalr};

		w = '0;
		w.alu.alu_op = decode_pkg::alu_add;
		case (op)
			decode_pkg::op_xori:  w.alu.alu_op = decode_pkg::alu_xor;
			decode_pkg::op_andni: w.alu.alu_op = decode_pkg::alu_and;
			decode_pkg::op_roli:  w.alu.alu_op = decode_pkg::alu_rol;
			decode_pkg::op_slli:  w.alu.alu_op = decode_pkg::alu_sll;
			decode_pkg::op_rori:  w.alu.alu_op = decode_pkg::alu_ror;
			decode_pkg::op_srli:  w.alu.alu_op = decode_pkg::alu_srl;
			decode_pkg::op_btr:   w.alu.alu_op = decode_pkg::alu_btr;
			decode_pkg::op_seq:   w.alu.alu_op = decode_pkg::alu_seq;
			decode_pkg::op_slt:   w.alu.alu_op = decode_pkg::alu_slt;
			decode_pkg::op_sle:   w.alu.alu_op = decode_pkg::alu_sle;
			decode_pkg::op_sco:   w.alu.alu_op = decode_pkg::alu_sco;
			decode_pkg::op_beqz:  w.alu.alu_op = decode_pkg::alu_beqz;
			decode_pkg::op_bnez:  w.alu.alu_op = decode_pkg::alu_bnez;
			decode_pkg::op_bltz:  w.alu.alu_op = decode_pkg::alu_bltz;
			decode_pkg::op_bgez:  w.alu.alu_op = decode_pkg::alu_bgez;
			decode_pkg::op_alu_shift: w.alu.alu_op = fn[1] ?
				(fn[0] ? decode_pkg::alu_srl : decode_pkg::alu_ror) :
				(fn[0] ? decode_pkg::alu_sll : decode_pkg::alu_rol);
			decode_pkg::op_alu_arith: if (fn[1])
				w.alu.alu_op = fn[0] ? decode_pkg::alu_and : decode_pkg::alu_xor;
			default: w.alu.alu_op = decode_pkg::alu_add;
		endcase
		w.alu.inv_a = is_sub;
		w.alu.cin = is_sub;
		w.alu.inv_b = is_andn;
		w.alu.sign = is_sub || op inside {decode_pkg::op_slt, decode_pkg::op_sle,
			decode_pkg::op_bltz, decode_pkg::op_bgez};
		w.alu.operand_b = r_fmt ? decode_pkg::opb_reg : decode_pkg::opb_imm;
		if (long_jump)
			w.alu.imm_sel = decode_pkg::imm11;
		else if (imm8s || op == decode_pkg::op_slbi)
			w.alu.imm_sel = decode_pkg::imm8;
		else
			w.alu.imm_sel = decode_pkg::imm5;
		w.alu.sign_ext = i1_sext || imm8s || long_jump;

		// Register file and memory
		w.rf_mem.reg_write = r_fmt || i1_zext || link || op inside {decode_pkg::op_addi,
			decode_pkg::op_subi, decode_pkg::op_ld, decode_pkg::op_stu,
			decode_pkg::op_lbi, decode_pkg::op_slbi};
		if (r_fmt)
			w.rf_mem.reg_dst = decode_pkg::dst_rd_r;
		else if (op inside {decode_pkg::op_stu, decode_pkg::op_lbi, decode_pkg::op_slbi})
			w.rf_mem.reg_dst = decode_pkg::dst_rs;
		else if (link)
			w.rf_mem.reg_dst = decode_pkg::dst_r7;
		else
			w.rf_mem.reg_dst = decode_pkg::dst_rd_i;
		if (op == decode_pkg::op_ld)
			w.rf_mem.wb_src = decode_pkg::wb_mem;
		else if (op == decode_pkg::op_lbi)
			w.rf_mem.wb_src = decode_pkg::wb_lbi;
		else if (op == decode_pkg::op_slbi)
			w.rf_mem.wb_src = decode_pkg::wb_slbi;
		else if (link)
			w.rf_mem.wb_src = decode_pkg::wb_link;
		w.rf_mem.mem_read = op == decode_pkg::op_ld;
		w.rf_mem.mem_write = op inside {decode_pkg::op_st, decode_pkg::op_stu};

		if (branch)
			w.pc.pc_src = decode_pkg::pc_branch;
		else if (long_jump)
			w.pc.pc_src = decode_pkg::pc_disp;
		else if (op inside {decode_pkg::op_jr, decode_pkg::op_jalr})
			w.pc.pc_src = decode_pkg::pc_reg;
		else
			w.pc.pc_src = decode_pkg::pc_seq;
		w.pc.halt = op == decode_pkg::op_halt;
		return w;
	endfunction

	task automatic drive(input logic [15:0] value, input logic valid);
		@(posedge clk);
		#5;
		instr = value;
		instr_valid = valid;
	endtask

	// Funct invariance, halt and no-op words from the sweep
	task automatic check_sweep();
		decode_pkg::ctrl_word_t w;
		decode_pkg::ctrl_word_t base;
		check_value("sweep word count", 32'(seen_words.size()), 32'd128);
		for (int op = 0; op < 32; op++) begin
			base = expected_ctrl({5'(op), 9'h0a5, 2'b00});
			for (int f = 0; f < 4; f++) begin
				w = seen_words[op * 4 + f];
				if (op != 26 && op != 27)
					check_value("ctrl", 32'(w), 32'(base));
				if (op <= 3) begin
					check_value("reg_write", 32'(w.rf_mem.reg_write), 32'd0);
					check_value("mem_read", 32'(w.rf_mem.mem_read), 32'd0);
					check_value("mem_write", 32'(w.rf_mem.mem_write), 32'd0);
					check_value("pc_src", 32'(w.pc.pc_src), 32'(decode_pkg::pc_seq));
					check_value("halt", 32'(w.pc.halt), 32'(op == 0));
				end
			end
			if (op == 26 || op == 27) begin
				assert (seen_words[op * 4 + 1] != seen_words[op * 4]) else
					stop_with_failure("Funct had no effect on a grouped R-format opcode");
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exp_valid = 1'b0;
			exp_ctrl = '0;
		end else begin
			exp_valid = instr_valid;
			if (instr_valid)
				exp_ctrl = expected_ctrl(instr);
		end
	end

	// Outputs are settled by the falling edge
	initial begin
		@(posedge clk);
		forever begin
			@(negedge clk);
			check_value("ctrl_valid", 32'(ctrl_valid), 32'(exp_valid));
			check_value("ctrl", 32'(ctrl), 32'(exp_ctrl));
			if (capturing && ctrl_valid)
				seen_words.push_back(ctrl);
		end
	end

	initial begin
		#(run_cycles * clk_period);
		stop_with_failure("Watchdog expired before the tests finished");
	end

	initial begin
		logic [15:0] rnd_instr;
		logic [15:0] rnd_valid;
		instr = '0;
		instr_valid = 1'b0;
		rst_n = 1'b0;
		capturing = 1'b0;
		lfsr_state = 32'hf838;
		repeat (4) @(posedge clk);
		#5;
		rst_n = 1'b1;
		drive(16'h0000, 1'b0);

		// All opcodes with all funct values, back to back
		capturing = 1'b1;
		for (int i = 0; i < 128; i++)
			drive({5'(i >> 2), 9'h0a5, 2'(i)}, 1'b1);
		drive(16'h0000, 1'b0);
		drive(16'h0000, 1'b0);
		capturing = 1'b0;
		check_sweep();

		for (int i = 0; i < random_items; i++) begin
			random_bits(16, rnd_instr);
			random_bits(1, rnd_valid);
			drive(rnd_instr, rnd_valid[0]);
		end
		drive(16'h0000, 1'b0);
		drive(16'h0000, 1'b0);

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire
